// File: design/bus_pkg.sv
/*
 * Z80 bus, I/O port map, SD port and clock-enable types.
 * Bus strobes are active low, as on the Z80 pins.
 */
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 16;                // CPU address
	localparam int DATA_W = 8;
	localparam int CE_W   = 6;                 // Divider counter

	// Outputs of the Z80 as seen by the glue
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] dout;
		logic              m1_n;
		logic              mreq_n;
		logic              iorq_n;
		logic              rd_n;
		logic              wr_n;
	} cpu_bus_t;

	// Decoded ports, low address byte only
	typedef enum logic [7:0] {
		IO_SWITCHES = 8'h00,
		IO_SD       = 8'h69,
		IO_PAGE0    = 8'h78,
		IO_PAGE1    = 8'h79,
		IO_PAGE2    = 8'h7A,
		IO_PAGE3    = 8'h7B,
		IO_PAGE_EN  = 8'h7C
	} io_port_e;

	// Bit positions in the SD port byte
	localparam int SD_MOSI_BIT = 0;
	localparam int SD_CS_BIT   = 3;
	localparam int SD_CLK_BIT  = 4;
	localparam int SD_MISO_BIT = 7;

	localparam logic [DATA_W-1:0] IDLE_DATA = 8'hFF;   // Floating bus

	typedef struct packed {
		logic mosi;
		logic clk;
		logic cs;
	} sd_spi_t;

	// ne = falling-edge strobe, pe = rising-edge strobe
	typedef struct packed {
		logic ne14m;
		logic ne7m3;
		logic pe7m3;
		logic ne3m6;
		logic pe3m6;
		logic ne1m8;
		logic pe1m8;
		logic ne921k;
		logic pe921k;
	} clk_en_t;

endpackage

`default_nettype wire

// File: design/clock_enables.sv
/*
 * Enable strobes divided down from clk_sys, one cycle wide each.
 * Strobes stay low while reset is high.
 */
`default_nettype none

module clock_enables (
	input  logic             clk_sys,
	input  logic             reset,
	output bus_pkg::clk_en_t clk_en
);
	import bus_pkg::*;

	logic [CE_W-1:0] ce;

	////////////////////////////////////////
	// Divider and strobe decode
	////////////////////////////////////////

	// ne pairs fire on all-zero low bits, pe when the top bit is set
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce     <= CE_W'(1);                 // Restart point
			clk_en <= '0;
		end else begin
			ce <= ce + 1'b1;

			clk_en.ne14m  <= ce[1:0] == 2'b00;                // Every 4
			clk_en.ne7m3  <= ce[2:0] == 3'b000;               // Every 8
			clk_en.pe7m3  <= ce[2:0] == 3'b100;
			clk_en.ne3m6  <= ce[3:0] == 4'b0000;              // Every 16
			clk_en.pe3m6  <= ce[3:0] == 4'b1000;
			clk_en.ne1m8  <= ce[4:0] == 5'b00000;             // Every 32
			clk_en.pe1m8  <= ce[4:0] == 5'b10000;
			clk_en.ne921k <= ce[5:0] == 6'b000000;            // Every 64
			clk_en.pe921k <= ce[5:0] == 6'b100000;
		end
	end

endmodule

`default_nettype wire

// File: design/io_ports.sv
/*
 * I/O write registers and the CPU read-data mux.
 * Decode uses address bits 7:0 only; interrupt acknowledge is ignored.
 */
`default_nettype none

module io_ports (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  bus_pkg::cpu_bus_t                cpu,
	input  logic [bus_pkg::DATA_W-1:0]       boot_switches,
	input  logic                             sd_miso,
	input  logic [bus_pkg::DATA_W-1:0]       mem_q,
	output logic [bus_pkg::DATA_W-1:0]       cpu_din,
	output bus_pkg::sd_spi_t                 sd_spi,
	output mem_pkg::page_regs_t              page_regs
);
	import bus_pkg::*;
	import mem_pkg::*;

	logic [7:0]        port;
	logic              io_cycle;
	logic              io_wr;
	logic              io_rd;
	logic              mem_rd;
	logic [DATA_W-1:0] sd_rd_data;

	assign port     = cpu.addr[7:0];
	assign io_cycle = !cpu.iorq_n && cpu.m1_n;   // M1 with IORQ is an int ack
	assign io_wr    = io_cycle && !cpu.wr_n;
	assign io_rd    = io_cycle && !cpu.rd_n;
	assign mem_rd   = !cpu.mreq_n && !cpu.rd_n;

	////////////////////////////////////////
	// Write registers
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_spi            <= '0;
			page_regs.sel     <= {PAGE_RESET3, PAGE_RESET2, PAGE_RESET1, PAGE_RESET0};
			page_regs.page_en <= 1'b1;
		end else if (io_wr) begin
			case (port)
				IO_SD: begin
					sd_spi.mosi <= cpu.dout[SD_MOSI_BIT];
					sd_spi.cs   <= cpu.dout[SD_CS_BIT];
					sd_spi.clk  <= cpu.dout[SD_CLK_BIT];
				end
				// Low two port bits give the window
				IO_PAGE0, IO_PAGE1, IO_PAGE2, IO_PAGE3:
					page_regs.sel[port[1:0]] <= cpu.dout;
				IO_PAGE_EN:
					page_regs.page_en <= cpu.dout[0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Read data select
	////////////////////////////////////////

	always_comb begin
		sd_rd_data              = '0;
		sd_rd_data[SD_MISO_BIT] = sd_miso;   // Other bits read as zero
	end

	always_comb begin
		if (io_rd && port == IO_SWITCHES)
			cpu_din = boot_switches;
		else if (io_rd && port == IO_SD)
			cpu_din = sd_rd_data;
		else if (mem_rd)
			cpu_din = mem_q;
		else
			cpu_din = IDLE_DATA;             // Nothing drives the bus
	end

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
/*
 * Memory map, page registers and loader types.
 * 1 MiB byte space; bit 19 set means RAM, clear means ROM.
 */
`default_nettype none

package mem_pkg;

	localparam int MEM_ADDR_W  = 20;
	localparam int WINDOW_W    = 14;         // 16 KiB window offset
	localparam int PAGE_W      = 6;          // Used bits of a page select
	localparam int NUM_WINDOWS = 4;
	localparam int RAM_BIT     = 19;

	// Page selects after reset, ROM low and RAM high
	localparam logic [7:0] PAGE_RESET0 = 8'h00;
	localparam logic [7:0] PAGE_RESET1 = 8'h01;
	localparam logic [7:0] PAGE_RESET2 = 8'h3E;
	localparam logic [7:0] PAGE_RESET3 = 8'h3F;

	// Full bytes are kept, only the low PAGE_W bits map
	typedef struct packed {
		logic [NUM_WINDOWS-1:0][7:0] sel;
		logic                        page_en;
	} page_regs_t;

	typedef struct packed {
		logic                  download;
		logic                  wr;
		logic [MEM_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} loader_t;

endpackage

`default_nettype wire

// File: design/page_mapper.sv
/*
 * Maps the 16-bit CPU address onto 20 bits through four 16 KiB windows.
 * Output is registered, so it lags cpu.addr by one cycle.
 */
`default_nettype none

module page_mapper (
	input  logic                               clk_sys,
	input  bus_pkg::cpu_bus_t                  cpu,
	input  mem_pkg::page_regs_t                page_regs,
	output logic [mem_pkg::MEM_ADDR_W-1:0]     mem_addr
);
	import bus_pkg::*;
	import mem_pkg::*;

	logic [$clog2(NUM_WINDOWS)-1:0] win;
	logic [PAGE_W-1:0]              page;

	assign win = cpu.addr[ADDR_W-1:WINDOW_W];     // Top two address bits

	// With paging off every window aliases page 0
	always_comb begin
		if (page_regs.page_en)
			page = page_regs.sel[win][PAGE_W-1:0];
		else
			page = '0;
	end

	always_ff @(posedge clk_sys) begin
		mem_addr <= {page, cpu.addr[WINDOW_W-1:0]};
	end

endmodule

`default_nettype wire

// File: design/rc2014_glue.sv
/*
 * Bus glue around the Z80: enables, I/O ports, paging and memory.
 * Hold reset high for the whole of a download.
 */
`default_nettype none

module rc2014_glue (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  bus_pkg::cpu_bus_t              cpu,
	input  logic [bus_pkg::DATA_W-1:0]     boot_switches,
	input  logic                           sd_miso,
	input  mem_pkg::loader_t               loader,
	output logic [bus_pkg::DATA_W-1:0]     cpu_din,
	output bus_pkg::sd_spi_t               sd_spi,
	output bus_pkg::clk_en_t               clk_en
);
	import bus_pkg::*;
	import mem_pkg::*;

	page_regs_t            page_regs;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0]     mem_q;

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clk_en  (clk_en)
	);

	io_ports u_io_ports (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu           (cpu),
		.boot_switches (boot_switches),
		.sd_miso       (sd_miso),
		.mem_q         (mem_q),
		.cpu_din       (cpu_din),
		.sd_spi        (sd_spi),
		.page_regs     (page_regs)
	);

	// CPU address to physical, one cycle
	page_mapper u_page_mapper (
		.clk_sys   (clk_sys),
		.cpu       (cpu),
		.page_regs (page_regs),
		.mem_addr  (mem_addr)
	);

	sys_memory u_sys_memory (
		.clk_sys  (clk_sys),
		.cpu      (cpu),
		.mem_addr (mem_addr),
		.loader   (loader),
		.mem_q    (mem_q)           // Second cycle of read latency
	);

endmodule

`default_nettype wire

// File: design/sys_memory.sv
/*
 * 1 MiB byte memory: ROM below RAM_BIT, RAM above it.
 * While download is high only loader writes land, anywhere in the map.
 */
`default_nettype none

module sys_memory (
	input  logic                               clk_sys,
	input  bus_pkg::cpu_bus_t                  cpu,
	input  logic [mem_pkg::MEM_ADDR_W-1:0]     mem_addr,
	input  mem_pkg::loader_t                   loader,
	output logic [bus_pkg::DATA_W-1:0]         mem_q
);
	import bus_pkg::*;
	import mem_pkg::*;

	logic [DATA_W-1:0] mem [0:2**MEM_ADDR_W-1];
	logic              cpu_wr;
	logic              ram_sel;

	assign cpu_wr  = !cpu.mreq_n && !cpu.wr_n;
	assign ram_sel = mem_addr[RAM_BIT];        // ROM half is write protected

	////////////////////////////////////////
	// Write ports and registered read
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (loader.download) begin
			if (loader.wr)
				mem[loader.addr] <= loader.data;
		end else if (cpu_wr && ram_sel) begin
			mem[mem_addr] <= cpu.dout;        // Repeats harmlessly on long cycles
		end
	end

	// Read every cycle, data follows mem_addr by one clock
	always_ff @(posedge clk_sys) begin
		mem_q <= mem[mem_addr];
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator.
# A failing run ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_rc2014_glue \
	-Mdir obj_dir \
	-f sim.f

./obj_dir/Vtb_rc2014_glue

// File: sim.f
design/bus_pkg.sv
design/mem_pkg.sv
design/clock_enables.sv
design/io_ports.sv
design/page_mapper.sv
design/sys_memory.sv
design/rc2014_glue.sv
verif/tb_rc2014_glue.sv

// File: verif/tb_rc2014_glue.sv
/*
 * Drives the Z80 bus of rc2014_glue directly, no CPU model.
 * Memory is only read back where the loader or a CPU write put known data.
 */
`default_nettype none

module tb_rc2014_glue;
	timeunit 1ns;
	timeprecision 100ps;

	import bus_pkg::*;
	import mem_pkg::*;

	localparam int CLK_PERIOD     = 10;
	localparam int RESET_CYCLES   = 10;
	localparam int NUM_PAGES      = 64;
	localparam int LOAD_CYCLES    = NUM_PAGES + 3;
	localparam int ACCESS_CYCLES  = 5;                 // Longest bus task
	localparam int NUM_ACCESSES   = 64;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + LOAD_CYCLES + ACCESS_CYCLES * NUM_ACCESSES);
	localparam int NUM_STROBES    = $bits(clk_en_t);
	localparam logic [WINDOW_W-1:0] MARK_OFS = 14'h0123;   // Marker byte in every page

	logic                  clk_sys = 1'b0;
	logic                  reset;
	cpu_bus_t              cpu;
	logic [DATA_W-1:0]     boot_switches;
	logic                  sd_miso;
	loader_t               loader;
	logic [DATA_W-1:0]     cpu_din;
	sd_spi_t               sd_spi;
	clk_en_t               clk_en;

	// Reference model
	logic [7:0]            model_mem [0:(1<<MEM_ADDR_W)-1];
	logic [7:0]            model_page [0:NUM_WINDOWS-1];
	logic                  model_page_en;
	sd_spi_t               model_sd;
	logic [31:0]           lcg_state = 32'd82;

	// Strobe tracking, clk_en bit 8 is ne14m and bit 0 is pe921k
	int                    cyc;
	int                    last_fire [0:NUM_STROBES-1];
	int                    n_fire [0:NUM_STROBES-1];

	rc2014_glue UUT (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu           (cpu),
		.boot_switches (boot_switches),
		.sd_miso       (sd_miso),
		.loader        (loader),
		.cpu_din       (cpu_din),
		.sd_spi        (sd_spi),
		.clk_en        (clk_en)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on error");
	endtask

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// Window from the top two bits, page 0 for all windows when paging is off
	function automatic logic [MEM_ADDR_W-1:0] predict_addr(input logic [ADDR_W-1:0] addr);
		logic [PAGE_W-1:0] page;
		page = model_page_en ? model_page[addr[15:14]][PAGE_W-1:0] : '0;
		return {page, addr[WINDOW_W-1:0]};
	endfunction

	// 4 cycles for ne14m, then each ne/pe pair doubles: 8, 16, 32, 64
	function automatic int strobe_period(input int idx);
		if (idx == NUM_STROBES - 1)
			return 4;
		return 8 << ((NUM_STROBES - 2 - idx) / 2);
	endfunction

	////////////////////////////////////////
	// Bus cycles, driven on falling edges
	////////////////////////////////////////

	task automatic bus_idle();
		cpu.m1_n   = 1'b1;
		cpu.mreq_n = 1'b1;
		cpu.iorq_n = 1'b1;
		cpu.rd_n   = 1'b1;
		cpu.wr_n   = 1'b1;
	endtask

	task automatic load_byte(input logic [MEM_ADDR_W-1:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		loader.wr   = 1'b1;
		loader.addr = addr;
		loader.data = data;
		model_mem[addr] = data;            // Loader writes ROM and RAM alike
	endtask

	task automatic check_mem_read(input logic [ADDR_W-1:0] addr);
		logic [MEM_ADDR_W-1:0] phys;
		logic [7:0]            expected;
		phys     = predict_addr(addr);
		expected = model_mem[phys];
		@(negedge clk_sys);
		cpu.addr   = addr;
		cpu.mreq_n = 1'b0;
		cpu.rd_n   = 1'b0;
		repeat (2) @(negedge clk_sys);     // Mapper then memory register
		assert (cpu_din === expected) else
			abort_run($sformatf("Fail t=%0t: read %h (phys %h) got %h, expected %h",
				$time, addr, phys, cpu_din, expected));
		bus_idle();
	endtask

	task automatic cpu_mem_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
		logic [MEM_ADDR_W-1:0] phys;
		phys = predict_addr(addr);
		@(negedge clk_sys);
		cpu.addr = addr;
		cpu.dout = data;
		repeat (2) @(negedge clk_sys);     // Address settles before the strobes
		cpu.mreq_n = 1'b0;
		cpu.wr_n   = 1'b0;
		@(negedge clk_sys);
		bus_idle();
		if (phys[RAM_BIT])
			model_mem[phys] = data;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(negedge clk_sys);
		cpu.addr   = {8'h00, port};
		cpu.dout   = data;
		cpu.iorq_n = 1'b0;
		cpu.wr_n   = 1'b0;
		@(negedge clk_sys);
		bus_idle();
		case (port)
			IO_PAGE0, IO_PAGE1, IO_PAGE2, IO_PAGE3: model_page[port[1:0]] = data;
			IO_PAGE_EN: model_page_en = data[0];
			IO_SD:      model_sd = '{mosi: data[0], clk: data[4], cs: data[3]};
			default: ;
		endcase
	endtask

	task automatic check_io_read(input logic [7:0] port, input logic [7:0] expected);
		@(negedge clk_sys);
		cpu.addr   = {8'h00, port};
		cpu.iorq_n = 1'b0;
		cpu.rd_n   = 1'b0;
		@(negedge clk_sys);
		assert (cpu_din === expected) else
			abort_run($sformatf("Fail t=%0t: I/O read %h got %h, expected %h",
				$time, port, cpu_din, expected));
		bus_idle();
	endtask

	////////////////////////////////////////
	// Clock enable checks
	////////////////////////////////////////

	assert property (@(posedge clk_sys) (reset && $past(reset)) |-> (clk_en == '0)) else
		abort_run($sformatf("Fail t=%0t: strobe active during reset", $time));
	assert property (@(posedge clk_sys) !(clk_en.ne7m3 && clk_en.pe7m3)) else
		abort_run($sformatf("Fail t=%0t: ne7m3 and pe7m3 coincide", $time));

	// Even bits are pe strobes, their ne partner sits one bit above
	always @(posedge clk_sys) begin
		if (reset) begin
			cyc = 0;
			for (int i = 0; i < NUM_STROBES; i++) begin
				last_fire[i] = -1;
				n_fire[i]    = 0;
			end
		end else begin
			cyc++;
			// ne before pe, so a coinciding pair shows a distance of 0
			for (int i = NUM_STROBES - 1; i >= 0; i--) begin
				if (clk_en[i]) begin
					assert (last_fire[i] < 0 || cyc - last_fire[i] == strobe_period(i)) else
						abort_run($sformatf("Fail t=%0t: strobe bit %0d period %0d",
							$time, i, cyc - last_fire[i]));
					if (i % 2 == 0 && i < NUM_STROBES - 1) begin
						assert (last_fire[i+1] < 0 ||
								cyc - last_fire[i+1] == strobe_period(i) / 2) else
							abort_run($sformatf("Fail t=%0t: strobe bit %0d out of step",
								$time, i));
					end
					last_fire[i] = cyc;
					n_fire[i]++;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		abort_run("Timeout: the tests did not finish within the watchdog limit");
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [7:0] pg;
		logic       strobes_seen;
		cpu = '{addr: '0, dout: '0, m1_n: 1'b1, mreq_n: 1'b1, iorq_n: 1'b1,
			rd_n: 1'b1, wr_n: 1'b1};
		boot_switches = 8'hA5;
		sd_miso       = 1'b0;
		loader        = '0;
		reset         = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		assert (sd_spi === '0) else
			abort_run($sformatf("Fail t=%0t: sd_spi %b after reset", $time, sd_spi));

		// Download under reset, one marker per page
		reset           = 1'b1;
		loader.download = 1'b1;
		for (int p = 0; p < NUM_PAGES; p++)
			load_byte({p[PAGE_W-1:0], MARK_OFS}, rand_byte());
		@(negedge clk_sys);
		loader = '0;
		@(negedge clk_sys);
		reset = 1'b0;
		model_page    = '{PAGE_RESET0, PAGE_RESET1, PAGE_RESET2, PAGE_RESET3};
		model_page_en = 1'b1;
		model_sd      = '0;

		// Reset mapping, ROM in window 0 and RAM in window 3
		for (int w = 0; w < NUM_WINDOWS; w++)
			check_mem_read({w[1:0], MARK_OFS});

		// ROM write ignored, RAM write lands
		cpu_mem_write({2'd0, MARK_OFS}, ~model_mem[predict_addr({2'd0, MARK_OFS})]);
		check_mem_read({2'd0, MARK_OFS});
		cpu_mem_write({2'd2, MARK_OFS}, ~model_mem[predict_addr({2'd2, MARK_OFS})]);
		check_mem_read({2'd2, MARK_OFS});

		// Random pages, alternating ROM and RAM
		for (int r = 0; r < 2; r++) begin
			for (int w = 0; w < NUM_WINDOWS; w++) begin
				pg    = rand_byte();
				pg[5] = w[0] ^ r[0];
				io_write(8'(IO_PAGE0 + w), pg);
			end
			for (int w = 0; w < NUM_WINDOWS; w++)
				check_mem_read({w[1:0], MARK_OFS});
			for (int w = 0; w < NUM_WINDOWS; w++) begin
				cpu_mem_write({w[1:0], MARK_OFS}, rand_byte());
				check_mem_read({w[1:0], MARK_OFS});
			end
		end
		io_write(IO_PAGE_EN, 8'h00);        // All windows alias page 0
		for (int w = 0; w < NUM_WINDOWS; w++)
			check_mem_read({w[1:0], MARK_OFS});

		// Ports
		check_io_read(IO_SWITCHES, boot_switches);
		sd_miso = 1'b1;
		check_io_read(IO_SD, 8'h80);
		sd_miso = 1'b0;
		check_io_read(IO_SD, 8'h00);
		io_write(IO_SD, 8'h19);
		assert (sd_spi === model_sd) else
			abort_run($sformatf("Fail t=%0t: sd_spi %b, expected %b", $time, sd_spi, model_sd));
		io_write(IO_SD, 8'h08);
		assert (sd_spi === model_sd) else
			abort_run($sformatf("Fail t=%0t: sd_spi %b, expected %b", $time, sd_spi, model_sd));
		check_io_read(8'h42, IDLE_DATA);    // Unmapped
		@(negedge clk_sys);
		assert (cpu_din === IDLE_DATA) else
			abort_run($sformatf("Fail t=%0t: idle bus read %h", $time, cpu_din));

		strobes_seen = 1'b1;
		for (int i = 0; i < NUM_STROBES; i++) begin
			if (n_fire[i] < 2)
				strobes_seen = 1'b0;
		end
		assert (strobes_seen) else
			abort_run("Clock enable strobes did not recur often enough after reset");
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
